// File: rvPkg.sv
package rvPkg;

	// major opcodes, inst[6:0]
	typedef enum logic [6:0] {
		opcLui    = 7'b0110111,
		opcAuipc  = 7'b0010111,
		opcJal    = 7'b1101111,
		opcJalr   = 7'b1100111,
		opcBranch = 7'b1100011,
		opcLoad   = 7'b0000011,
		opcStore  = 7'b0100011,
		opcOpImm  = 7'b0010011,
		opcOp     = 7'b0110011,
		opcSystem = 7'b1110011
	} opcodeE;

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluSll,
		aluSlt,
		aluSltu,
		aluXor,
		aluSrl,
		aluSra,
		aluOr,
		aluAnd,
		aluPassB   // lui
	} aluOpE;

	typedef enum logic [1:0] {
		sizeByte,
		sizeHalf,
		sizeWord
	} accessSizeE;

	typedef enum logic [1:0] {
		wbAlu,
		wbLoad,
		wbPcPlus4
	} wbSelE;

	typedef struct packed {
		aluOpE      aluOp;
		logic       aluSrcImm;   // operand b from imm
		logic       aluSrcPc;    // operand a from pc
		logic       regWrite;
		wbSelE      wbSel;
		logic       memRead;
		logic       memWrite;
		accessSizeE size;
		logic       loadUnsigned;
		logic       isBranch;
		logic       isJal;
		logic       isJalr;
		logic       isEbreak;
		logic [2:0] funct3;      // branch condition
	} ctrlT;

	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] wdata;   // lane aligned
		logic [3:0]  byteEn;
		logic        read;
		logic        write;
	} dataReqT;

endpackage

// File: rvDecoder.sv
`timescale 1ns/1ps

module rvDecoder (
	input  logic [31:0]  inst,
	output rvPkg::ctrlT  ctrl,
	output logic [31:0]  imm
);

	logic [2:0] funct3;
	logic       funct7b5;
	logic [31:0] immI, immS, immB, immU, immJ;

	assign funct3   = inst[14:12];
	assign funct7b5 = inst[30];

	assign immI = {{20{inst[31]}}, inst[31:20]};
	assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign immU = {inst[31:12], 12'b0};
	assign immJ = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	// sub only exists in the register form, sra in both
	function automatic rvPkg::aluOpE aluFromFunct(input logic [2:0] f3, input logic alt,
			input logic regOp);
		case (f3)
			3'b000:  return (regOp && alt) ? rvPkg::aluSub : rvPkg::aluAdd;
			3'b001:  return rvPkg::aluSll;
			3'b010:  return rvPkg::aluSlt;
			3'b011:  return rvPkg::aluSltu;
			3'b100:  return rvPkg::aluXor;
			3'b101:  return alt ? rvPkg::aluSra : rvPkg::aluSrl;
			3'b110:  return rvPkg::aluOr;
			default: return rvPkg::aluAnd;
		endcase
	endfunction

	always_comb begin
		ctrl = '0; // no writes unless the opcode is known
		ctrl.aluOp = rvPkg::aluAdd;
		ctrl.wbSel = rvPkg::wbAlu;
		ctrl.size = inst[13] ? rvPkg::sizeWord : (inst[12] ? rvPkg::sizeHalf : rvPkg::sizeByte);
		ctrl.loadUnsigned = inst[14];
		ctrl.funct3 = funct3;
		imm = immI;

		case (rvPkg::opcodeE'(inst[6:0]))
			rvPkg::opcLui: begin
				ctrl.aluOp = rvPkg::aluPassB;
				ctrl.aluSrcImm = 1'b1;
				ctrl.regWrite = 1'b1;
				imm = immU;
			end
			rvPkg::opcAuipc: begin
				ctrl.aluSrcPc = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.regWrite = 1'b1;
				imm = immU;
			end
			rvPkg::opcJal: begin
				ctrl.isJal = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.wbSel = rvPkg::wbPcPlus4;
				imm = immJ;
			end
			rvPkg::opcJalr: begin
				ctrl.isJalr = 1'b1;
				ctrl.aluSrcImm = 1'b1; // target from rs1 + imm
				ctrl.regWrite = 1'b1;
				ctrl.wbSel = rvPkg::wbPcPlus4;
			end
			rvPkg::opcBranch: begin
				ctrl.isBranch = 1'b1;
				imm = immB;
			end
			rvPkg::opcLoad: begin
				ctrl.aluSrcImm = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.wbSel = rvPkg::wbLoad;
			end
			rvPkg::opcStore: begin
				ctrl.aluSrcImm = 1'b1;
				ctrl.memWrite = 1'b1;
				imm = immS;
			end
			rvPkg::opcOpImm: begin
				ctrl.aluOp = aluFromFunct(funct3, funct7b5, 1'b0);
				ctrl.aluSrcImm = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			rvPkg::opcOp: begin
				ctrl.aluOp = aluFromFunct(funct3, funct7b5, 1'b1);
				ctrl.regWrite = 1'b1;
			end
			rvPkg::opcSystem: ctrl.isEbreak = (inst == 32'h0010_0073);
			default: ;
		endcase
	end

endmodule

// File: rvRegFile.sv
`timescale 1ns/1ps

module rvRegFile #(
	parameter int regCount = 32
) (
	input  logic        clk,
	input  logic        arstN,
	input  logic        we,
	input  logic [4:0]  rs1,
	input  logic [4:0]  rs2,
	input  logic [4:0]  rd,
	input  logic [31:0] wdata,
	output logic [31:0] rdata1,
	output logic [31:0] rdata2
);

	localparam int idxW = $clog2(regCount); // 4 for rv32e

	logic [31:0] regs [regCount];
	logic [idxW-1:0] idx1, idx2, idxW_;

	assign idx1   = rs1[idxW-1:0];
	assign idx2   = rs2[idxW-1:0];
	assign idxW_  = rd[idxW-1:0];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			regs <= '{default: '0};
		end else if (we && idxW_ != '0) begin
			regs[idxW_] <= wdata;
		end
	end

	// x0 is hardwired
	assign rdata1 = (idx1 == '0) ? '0 : regs[idx1];
	assign rdata2 = (idx2 == '0) ? '0 : regs[idx2];

endmodule

// File: rvAlu.sv
`timescale 1ns/1ps

module rvAlu (
	input  rvPkg::aluOpE op,
	input  logic [31:0]  a,
	input  logic [31:0]  b,
	input  logic [31:0]  rs1Val,
	input  logic [31:0]  rs2Val,
	input  logic [2:0]   funct3,
	output logic [31:0]  result,
	output logic         branchTaken
);

	logic [4:0] shamt;
	logic       eq, ltS, ltU;

	assign shamt = b[4:0];

	always_comb begin
		case (op)
			rvPkg::aluAdd:   result = a + b;
			rvPkg::aluSub:   result = a - b;
			rvPkg::aluSll:   result = a << shamt;
			rvPkg::aluSlt:   result = {31'b0, $signed(a) < $signed(b)};
			rvPkg::aluSltu:  result = {31'b0, a < b};
			rvPkg::aluXor:   result = a ^ b;
			rvPkg::aluSrl:   result = a >> shamt;
			rvPkg::aluSra:   result = $unsigned($signed(a) >>> shamt);
			rvPkg::aluOr:    result = a | b;
			rvPkg::aluAnd:   result = a & b;
			rvPkg::aluPassB: result = b;
			default:         result = '0;
		endcase
	end

	// branch compare works on the raw register values
	assign eq  = rs1Val == rs2Val;
	assign ltS = $signed(rs1Val) < $signed(rs2Val);
	assign ltU = rs1Val < rs2Val;

	always_comb begin
		case (funct3)
			3'b000:  branchTaken = eq;    // beq
			3'b001:  branchTaken = !eq;   // bne
			3'b100:  branchTaken = ltS;
			3'b101:  branchTaken = !ltS;
			3'b110:  branchTaken = ltU;
			3'b111:  branchTaken = !ltU;
			default: branchTaken = 1'b0;
		endcase
	end

endmodule

// File: rvLoadStore.sv
`timescale 1ns/1ps

module rvLoadStore (
	input  rvPkg::ctrlT    ctrl,
	input  logic           enable,
	input  logic [31:0]    addr,
	input  logic [31:0]    storeVal,
	input  logic [31:0]    readData,
	output rvPkg::dataReqT req,
	output logic [31:0]    loadVal
);

	logic [31:0] lane;      // addressed lane moved to bit 0
	logic [3:0]  mask;

	assign req.addr  = addr;
	assign req.read  = enable && ctrl.memRead;
	assign req.write = enable && ctrl.memWrite;

	always_comb begin
		case (ctrl.size)
			rvPkg::sizeByte: begin
				req.wdata = {4{storeVal[7:0]}};
				mask = 4'b0001 << addr[1:0];
			end
			rvPkg::sizeHalf: begin
				req.wdata = {2{storeVal[15:0]}};
				mask = addr[1] ? 4'b1100 : 4'b0011;
			end
			default: begin
				req.wdata = storeVal;
				mask = 4'b1111;
			end
		endcase
	end

	assign req.byteEn = req.write ? mask : 4'b0000;

	assign lane = readData >> {addr[1:0], 3'b000};

	always_comb begin
		case (ctrl.size)
			rvPkg::sizeByte:
				loadVal = ctrl.loadUnsigned ? {24'b0, lane[7:0]} : {{24{lane[7]}}, lane[7:0]};
			rvPkg::sizeHalf:
				loadVal = ctrl.loadUnsigned ? {16'b0, lane[15:0]}
					: {{16{lane[15]}}, lane[15:0]};
			default:
				loadVal = readData;
		endcase
	end

endmodule

// File: rvCore.sv
`timescale 1ns/1ps

module rvCore #(
	parameter logic [31:0] resetVector = 32'h8000_0000,
	parameter int          regCount    = 32
) (
	input  logic           clk,
	input  logic           arstN,
	input  logic [31:0]    inst,
	input  logic [31:0]    readData,
	output logic [31:0]    pc,
	output rvPkg::dataReqT dataReq,
	output logic           halt
);

	typedef enum logic {
		stRunning,
		stHalted
	} runStateE;

	runStateE    state;
	rvPkg::ctrlT ctrl;
	logic [31:0] imm;
	logic [31:0] rdata1, rdata2;
	logic [31:0] aluA, aluB, aluResult;
	logic        branchTaken;
	logic [31:0] loadVal;
	logic [31:0] pcPlus4, pcTarget, nextPc;
	logic [31:0] wbData;
	logic        active;

	// no side effects during reset or after ebreak
	assign active = arstN && (state == stRunning);
	assign halt   = (state == stHalted);

	rvDecoder decoder (
		.inst (inst),
		.ctrl (ctrl),
		.imm  (imm)
	);

	rvRegFile #(.regCount(regCount)) regFile (
		.clk    (clk),
		.arstN  (arstN),
		.we     (ctrl.regWrite && active),
		.rs1    (inst[19:15]),
		.rs2    (inst[24:20]),
		.rd     (inst[11:7]),
		.wdata  (wbData),
		.rdata1 (rdata1),
		.rdata2 (rdata2)
	);

	assign aluA = ctrl.aluSrcPc ? pc : rdata1;
	assign aluB = ctrl.aluSrcImm ? imm : rdata2;

	rvAlu alu (
		.op          (ctrl.aluOp),
		.a           (aluA),
		.b           (aluB),
		.rs1Val      (rdata1),
		.rs2Val      (rdata2),
		.funct3      (ctrl.funct3),
		.result      (aluResult),
		.branchTaken (branchTaken)
	);

	rvLoadStore loadStore (
		.ctrl     (ctrl),
		.enable   (active),
		.addr     (aluResult),
		.storeVal (rdata2),
		.readData (readData),
		.req      (dataReq),
		.loadVal  (loadVal)
	);

	assign pcPlus4  = pc + 32'd4;
	assign pcTarget = pc + imm;

	always_comb begin
		if (ctrl.isJalr)
			nextPc = {aluResult[31:1], 1'b0};
		else if (ctrl.isJal || (ctrl.isBranch && branchTaken))
			nextPc = pcTarget;
		else
			nextPc = pcPlus4;
	end

	always_comb begin
		case (ctrl.wbSel)
			rvPkg::wbLoad:    wbData = loadVal;
			rvPkg::wbPcPlus4: wbData = pcPlus4; // link
			default:          wbData = aluResult;
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= resetVector;
			state <= stRunning;
		end else if (state == stRunning) begin
			pc <= nextPc;
			if (ctrl.isEbreak)
				state <= stHalted;
		end
	end

endmodule

// File: tbRvCore.sv
`timescale 1ns/1ps

module tbRvCore;

	localparam logic [31:0] resetVec = 32'h8000_0000;
	localparam logic [31:0] opLui    = 32'b0110111;
	localparam logic [31:0] opJalr   = 32'b1100111;
	localparam logic [31:0] opLoad   = 32'b0000011;
	localparam logic [31:0] opImm    = 32'b0010011;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] inst;
		logic        write;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [3:0]  byteEn;
	} rowT;

	logic           clk;
	logic           arstN;
	logic [31:0]    inst;
	logic [31:0]    readData;
	logic [31:0]    pc;
	rvPkg::dataReqT dataReq;
	logic           halt;

	logic [31:0] ram [64];
	rowT         rows [$];
	logic [31:0] ep;       // expected pc of the next row
	int          errors;
	int          checks;
	int          cycles;

	rvCore uut (
		.clk      (clk),
		.arstN    (arstN),
		.inst     (inst),
		.readData (readData),
		.pc       (pc),
		.dataReq  (dataReq),
		.halt     (halt)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// data RAM indexed by addr[7:2]
	assign readData = ram[dataReq.addr[7:2]];

	always @(posedge clk) begin
		if (dataReq.write) begin
			for (int b = 0; b < 4; b++) begin
				if (dataReq.byteEn[b])
					ram[dataReq.addr[7:2]][b*8 +: 8] <= dataReq.wdata[b*8 +: 8];
			end
		end
	end

	function automatic logic [31:0] rType(input logic [31:0] f7, rs2, rs1, f3, rd);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
	endfunction

	function automatic logic [31:0] iType(input logic [31:0] imm, rs1, f3, rd, opc);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
	endfunction

	function automatic logic [31:0] sType(input logic [31:0] imm, rs2, rs1, f3);
		return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] bType(input logic [31:0] imm, rs1, rs2, f3);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
			7'b1100011};
	endfunction

	function automatic logic [31:0] uType(input logic [31:0] imm, rd, opc);
		return {imm[19:0], rd[4:0], opc[6:0]};
	endfunction

	function automatic logic [31:0] jType(input logic [31:0] imm, rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
	endfunction

	task automatic addRow(input logic [31:0] ins, input logic wr, input logic [31:0] ad,
			input logic [31:0] wd, input logic [3:0] be);
		rowT r;
		r.pc = ep;
		r.inst = ins;
		r.write = wr;
		r.addr = ad;
		r.wdata = wd;
		r.byteEn = be;
		rows.push_back(r);
		ep = ep + 4;
	endtask

	task automatic addOp(input logic [31:0] ins);
		addRow(ins, 1'b0, 32'h0, 32'h0, 4'h0);
	endtask

	task automatic addStore(input logic [31:0] ins, input logic [31:0] ad,
			input logic [31:0] wd, input logic [3:0] be);
		addRow(ins, 1'b1, ad, wd, be);
	endtask

	// sw rs2, off(x0)
	task automatic storeWord(input logic [31:0] rs2, input logic [31:0] off,
			input logic [31:0] wd);
		addStore(sType(off, rs2, 0, 2), off, wd, 4'hF);
	endtask

	task automatic addBranch(input logic [31:0] ins, input logic taken, input logic [31:0] off);
		logic [31:0] at;
		at = ep;
		addOp(ins);
		if (taken)
			ep = at + off;
	endtask

	task automatic buildTable();
		logic [31:0] jalPc;
		logic [31:0] basePc;
		logic [31:0] jalrPc;
		ep = resetVec;
		addOp(uType(32'h12345, 1, opLui));
		addOp(iType(32'h678, 1, 0, 1, opImm));   // x1 = 12345678
		addOp(iType(-16, 0, 0, 2, opImm));
		addOp(rType(0, 2, 1, 0, 3));             // add
		addOp(rType(32, 2, 1, 0, 4));            // sub
		addOp(rType(0, 2, 1, 4, 5));             // xor
		addOp(iType(4, 0, 0, 6, opImm));
		addOp(rType(0, 6, 1, 1, 7));             // sll by x6
		addOp(iType(32'h402, 2, 5, 8, opImm));   // srai 2
		addOp(rType(0, 2, 1, 3, 9));             // sltu
		addOp(iType(5, 0, 0, 0, opImm));         // x0 stays zero
		storeWord(3, 0, 32'h1234_5668);
		storeWord(4, 4, 32'h1234_5688);
		storeWord(5, 8, 32'hEDCB_A988);
		storeWord(7, 12, 32'h2345_6780);
		storeWord(8, 16, 32'hFFFF_FFFC);
		storeWord(9, 20, 32'h0000_0001);
		storeWord(0, 24, 32'h0000_0000);
		addStore(sType(32, 1, 0, 0), 32, 32'h7878_7878, 4'b0001);
		addStore(sType(33, 1, 0, 0), 33, 32'h7878_7878, 4'b0010);
		addStore(sType(34, 1, 0, 0), 34, 32'h7878_7878, 4'b0100);
		addStore(sType(35, 1, 0, 0), 35, 32'h7878_7878, 4'b1000);
		addStore(sType(36, 1, 0, 1), 36, 32'h5678_5678, 4'b0011);
		addStore(sType(38, 1, 0, 1), 38, 32'h5678_5678, 4'b1100);
		// lanes of 80FF7F01 at addr 64
		addOp(iType(67, 0, 0, 11, opLoad));
		storeWord(11, 80, 32'hFFFF_FF80);
		addOp(iType(66, 0, 4, 12, opLoad));
		storeWord(12, 84, 32'h0000_00FF);
		addOp(iType(66, 0, 1, 13, opLoad));
		storeWord(13, 88, 32'hFFFF_80FF);
		addOp(iType(66, 0, 5, 14, opLoad));
		storeWord(14, 92, 32'h0000_80FF);
		addOp(iType(64, 0, 1, 15, opLoad));
		storeWord(15, 96, 32'h0000_7F01);
		addOp(iType(64, 0, 2, 16, opLoad));
		storeWord(16, 100, 32'h80FF_7F01);
		addBranch(bType(8, 1, 1, 0), 1'b1, 8);    // beq
		addBranch(bType(8, 1, 2, 0), 1'b0, 8);
		addBranch(bType(12, 1, 2, 1), 1'b1, 12);  // bne
		addBranch(bType(8, 1, 1, 1), 1'b0, 8);
		addBranch(bType(8, 2, 1, 4), 1'b1, 8);    // blt with -16 < x1
		addBranch(bType(8, 1, 2, 4), 1'b0, 8);
		addBranch(bType(8, 2, 1, 7), 1'b1, 8);    // bgeu
		addBranch(bType(8, 1, 2, 7), 1'b0, 8);
		jalPc = ep;
		addOp(jType(12, 20));
		ep = jalPc + 12;
		storeWord(20, 104, jalPc + 4);
		// jalr to an odd sum with bit 0 cleared
		basePc = ep;
		addOp(uType(32'h80000, 21, opLui));
		addOp(iType(basePc + 19, 21, 0, 21, opImm));
		jalrPc = ep;
		addOp(iType(2, 21, 0, 22, opJalr));
		ep = basePc + 20;
		storeWord(22, 108, jalrPc + 4);
		addOp(32'h0010_0073);                    // ebreak
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			$display("FAILED %s: got %h, expected %h at %0t", name, got, exp, $time);
			errors++;
		end
	endtask

	initial begin
		errors = 0;
		checks = 0;
		arstN = 1'b0;
		inst = 32'h0000_0013;
		for (int i = 0; i < 64; i++)
			ram[i] = 32'hC0DE_0000 + i * 4;
		ram[16] = 32'h80FF_7F01;
		buildTable();

		repeat (10) @(posedge clk);
		#2;
		check("pc", pc, resetVec);
		check("dataReq.read", 32'(dataReq.read), 32'h0);
		check("dataReq.write", 32'(dataReq.write), 32'h0);
		arstN = 1'b1;
		check("halt", 32'(halt), 32'h0);

		for (int i = 0; i < rows.size(); i++) begin
			check("pc", pc, rows[i].pc);
			inst = rows[i].inst;
			#10;
			check("dataReq.read", 32'(dataReq.read), 32'(rows[i].inst[6:0] == opLoad[6:0]));
			check("dataReq.write", 32'(dataReq.write), 32'(rows[i].write));
			check("dataReq.byteEn", 32'(dataReq.byteEn), 32'(rows[i].byteEn));
			if (rows[i].write) begin
				check("dataReq.addr", dataReq.addr, rows[i].addr);
				check("dataReq.wdata", dataReq.wdata, rows[i].wdata);
			end
			@(posedge clk);
			#2;
		end

		cycles = 0;
		while (!halt && cycles < 20) begin
			@(posedge clk);
			#2;
			cycles++;
		end
		if (!halt) begin
			$display("halt did not rise within %0d cycles after ebreak", cycles);
			errors++;
		end else begin
			check("pc", pc, ep);
			inst = sType(0, 1, 0, 2);  // a store must not reach the port now
			repeat (5) begin
				#10;
				check("dataReq.write", 32'(dataReq.write), 32'h0);
				check("halt", 32'(halt), 32'h1);
				@(posedge clk);
				#2;
				check("pc", pc, ep);
			end
		end

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: list.f
rvPkg.sv
rvDecoder.sv
rvRegFile.sv
rvAlu.sv
rvLoadStore.sv
rvCore.sv
tbRvCore.sv

// File: run.sh
#!/bin/sh
# builds the core and testbench with Verilator, then runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tbRvCore -f list.f

out=$(./obj_dir/VtbRvCore)
echo "$out"

echo "$out" | grep -q "^=== PASS ===$"
